// File: hw/lmu_seq_pkg.sv
`default_nettype none

package lmu_seq_pkg;

	////////////////////
	// sequence id layout
	////////////////////

	localparam int SEQ_ID_WIDTH = 33;

	// scoreboard id, top field
	localparam int SB_WIDTH = 4;
	localparam int SB_LSB = 29;

	// elements carried by the beat
	localparam int EL_COUNT_LSB = 22;
	localparam int EL_COUNT_WIDTH = 7;

	// first source element in the line
	localparam int OFFSET_LSB = 16;
	localparam int OFFSET_WIDTH = 6;

	// first destination element id
	localparam int EL_ID_LSB = 5;
	localparam int EL_ID_WIDTH = 11;

	////////////////////
	// load table
	////////////////////

	// sew codes 0..3 map to 8, 16, 32, 64 bits
	localparam int SEW_CODE_WIDTH = 2;
	localparam int STRIDE_WIDTH = 64;
	// element stride 1..4
	localparam int ELEM_STRIDE_WIDTH = 3;
	localparam int NUM_SLOTS = 2;
	// holds el_id + el_count
	localparam int VSTART_WIDTH = 12;

endpackage

`default_nettype wire

// File: hw/lmu_data_pkg.sv
`default_nettype none

package lmu_data_pkg;

	////////////////////
	// lane geometry
	////////////////////

	localparam int LANE_BITS = 64;
	localparam int LANE_BYTES = 8;

	// one 64-bit lane, seen at each element width
	typedef union packed {
		// sew 8
		logic [7:0][7:0] b;
		// sew 16
		logic [3:0][15:0] h;
		// sew 32
		logic [1:0][31:0] w;
		// sew 64, also the flat view
		logic [63:0] d;
	} lane_word_u;

endpackage

`default_nettype wire

// File: hw/lmu_load_tracker.sv
`default_nettype none

module lmu_load_tracker #(
	parameter int NUM_LANES = 8
) (
	input  logic                                         clk_i,
	input  logic                                         rst_n_i,
	input  logic                                         kill_i,
	input  logic                                         load_granted_i,
	input  logic [lmu_seq_pkg::SB_WIDTH-1:0]             granted_sb_id_i,
	input  logic                                         indexed_i,
	input  logic [lmu_seq_pkg::SEW_CODE_WIDTH-1:0]       sew_i,
	input  logic signed [lmu_seq_pkg::STRIDE_WIDTH-1:0]  stride_i,
	input  logic                                         sync_end_i,
	input  logic [lmu_seq_pkg::SB_WIDTH-1:0]             sync_end_sb_id_i,
	input  logic                                         data_valid_i,
	input  logic [lmu_seq_pkg::SEQ_ID_WIDTH-1:0]         seq_id_i,
	output logic                                         beat_valid_o,
	output logic [lmu_seq_pkg::SEW_CODE_WIDTH-1:0]       sew_o,
	output logic                                         reverse_o,
	output logic [lmu_seq_pkg::ELEM_STRIDE_WIDTH-1:0]    elem_stride_o,
	output logic [lmu_seq_pkg::OFFSET_WIDTH-1:0]         offset_o,
	output logic [lmu_seq_pkg::EL_ID_WIDTH-1:0]          el_id_o,
	output logic [lmu_seq_pkg::EL_COUNT_WIDTH-1:0]       el_count_o,
	output logic [lmu_seq_pkg::SB_WIDTH-1:0]             sb_id_o,
	output logic [lmu_seq_pkg::VSTART_WIDTH-1:0]         vstart_self_o,
	output logic [lmu_seq_pkg::VSTART_WIDTH-1:0]         vstart_next_o
);
	import lmu_seq_pkg::*;
	import lmu_data_pkg::*;

	localparam int LINE_BYTES = NUM_LANES * LANE_BYTES;
	localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);

	logic [NUM_SLOTS-1:0] live_q;
	logic [NUM_SLOTS-1:0][SB_WIDTH-1:0] sb_q;
	logic [NUM_SLOTS-1:0][SEW_CODE_WIDTH-1:0] sew_q;
	logic [NUM_SLOTS-1:0] neg_q;
	logic [NUM_SLOTS-1:0] idx_q;
	logic [NUM_SLOTS-1:0][ELEM_STRIDE_WIDTH-1:0] estr_q;

	logic [NUM_SLOTS-1:0] grant_sel;
	logic [NUM_SLOTS-1:0] end_sel;
	logic [NUM_SLOTS-1:0] grant_dup;
	logic [NUM_SLOTS-1:0] hit_vec;
	logic [SLOT_IDX_W-1:0] hit_idx;
	logic [STRIDE_WIDTH-1:0] stride_abs;
	logic [STRIDE_WIDTH-1:0] stride_elems;
	logic [SB_WIDTH-1:0] beat_sb;
	logic [EL_COUNT_WIDTH-1:0] beat_count;
	logic [OFFSET_WIDTH-1:0] offset_wrap;

	////////////////////
	// table update
	////////////////////

	// first free slot, slot 0 first
	always_comb begin
		logic taken;
		taken = 1'b0;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			grant_sel[s] = load_granted_i && !live_q[s] && !taken;
			taken = taken || !live_q[s];
			end_sel[s] = sync_end_i && live_q[s] && (sb_q[s] == sync_end_sb_id_i);
			grant_dup[s] = live_q[s] && (sb_q[s] == granted_sb_id_i);
		end
	end

	// byte stride to element stride
	assign stride_abs = stride_i[STRIDE_WIDTH-1] ? -stride_i : stride_i;
	assign stride_elems = stride_abs >> sew_i;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			live_q <= '0;
		end else if (kill_i) begin
			live_q <= '0;
		end else begin
			live_q <= (live_q & ~end_sel) | grant_sel;
		end
	end

	always_ff @(posedge clk_i) begin
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (grant_sel[s]) begin
				sb_q[s] <= granted_sb_id_i;
				sew_q[s] <= sew_i;
				neg_q[s] <= stride_i[STRIDE_WIDTH-1];
				idx_q[s] <= indexed_i;
				estr_q[s] <= stride_elems[ELEM_STRIDE_WIDTH-1:0];
			end
		end
	end

	////////////////////
	// beat lookup
	////////////////////

	assign beat_sb = seq_id_i[SB_LSB +: SB_WIDTH];
	assign beat_count = seq_id_i[EL_COUNT_LSB +: EL_COUNT_WIDTH];

	always_comb begin
		hit_idx = '0;
		for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
			hit_vec[s] = live_q[s] && (sb_q[s] == beat_sb);
			if (hit_vec[s]) begin
				hit_idx = SLOT_IDX_W'(s);
			end
		end
	end

	assign beat_valid_o = data_valid_i && (|hit_vec);

	// offset modulo elements per line
	assign offset_wrap = OFFSET_WIDTH'((LINE_BYTES >> sew_q[hit_idx]) - 1);

	assign sew_o = sew_q[hit_idx];
	assign reverse_o = neg_q[hit_idx] && !idx_q[hit_idx];
	assign elem_stride_o = (idx_q[hit_idx] || !beat_valid_o) ? ELEM_STRIDE_WIDTH'(1)
		: estr_q[hit_idx];
	assign offset_o = seq_id_i[OFFSET_LSB +: OFFSET_WIDTH] & offset_wrap;
	assign el_id_o = seq_id_i[EL_ID_LSB +: EL_ID_WIDTH];
	// no elements reach the lanes without a hit
	assign el_count_o = beat_valid_o ? beat_count : '0;
	assign sb_id_o = beat_sb;
	assign vstart_self_o = VSTART_WIDTH'(el_id_o);
	assign vstart_next_o = VSTART_WIDTH'(el_id_o) + VSTART_WIDTH'(beat_count);

	////////////////////
	// grant protocol
	////////////////////

	a_grant_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i || kill_i)
		load_granted_i |-> !(&live_q))
		else $error("grant while both slots are live");

	a_grant_live_id: assert property (@(posedge clk_i) disable iff (!rst_n_i || kill_i)
		load_granted_i |-> !(|grant_dup))
		else $error("grant of an id that is already live");

	a_grant_and_end: assert property (@(posedge clk_i) disable iff (!rst_n_i || kill_i)
		(load_granted_i && sync_end_i) |-> (granted_sb_id_i != sync_end_sb_id_i))
		else $error("grant and sync-end of the same id");

endmodule

`default_nettype wire

// File: hw/lmu_lane_gather.sv
`default_nettype none

module lmu_lane_gather #(
	parameter int NUM_LANES = 8,
	parameter int LANE_INDEX = 0
) (
	input  logic [NUM_LANES*lmu_data_pkg::LANE_BITS-1:0]  line_i,
	input  logic [lmu_seq_pkg::SEW_CODE_WIDTH-1:0]        sew_i,
	input  logic                                          reverse_i,
	input  logic [lmu_seq_pkg::ELEM_STRIDE_WIDTH-1:0]     elem_stride_i,
	input  logic [lmu_seq_pkg::OFFSET_WIDTH-1:0]          offset_i,
	input  logic [lmu_seq_pkg::EL_ID_WIDTH-1:0]           el_id_i,
	input  logic [lmu_seq_pkg::EL_COUNT_WIDTH-1:0]        el_count_i,
	input  logic                                          mask_valid_i,
	input  logic [NUM_LANES*lmu_data_pkg::LANE_BYTES-1:0] mask_i,
	output lmu_data_pkg::lane_word_u                      lane_data_o,
	output logic [lmu_data_pkg::LANE_BYTES-1:0]           lane_be_o
);
	import lmu_seq_pkg::*;
	import lmu_data_pkg::*;

	localparam int LINE_BYTES = NUM_LANES * LANE_BYTES;
	localparam int IDX_W = $clog2(LINE_BYTES);

	// elements per line minus one
	logic [IDX_W-1:0] n_mask;
	logic [LANE_BYTES-1:0] slot_ok;
	logic [LANE_BYTES-1:0] slot_be;
	logic [LANE_BYTES-1:0][IDX_W-1:0] slot_src;

	assign n_mask = IDX_W'((LINE_BYTES >> sew_i) - 1);

	////////////////////
	// slot selection
	////////////////////

	// only the first 8 >> sew slots are used
	always_comb begin
		logic [IDX_W-1:0] g;
		logic [IDX_W-1:0] rel;
		logic [IDX_W-1:0] src;
		for (int e = 0; e < LANE_BYTES; e++) begin
			// global element index of this slot
			g = IDX_W'(LANE_INDEX * (LANE_BYTES >> sew_i) + e);
			// j, relative to the first destination
			rel = (g - el_id_i[IDX_W-1:0]) & n_mask;
			src = (offset_i[IDX_W-1:0] + rel * elem_stride_i) & n_mask;
			// mirrored line for negative strides
			if (reverse_i) begin
				src = n_mask - src;
			end
			slot_src[e] = src;
			slot_ok[e] = EL_COUNT_WIDTH'(rel) < el_count_i;
			slot_be[e] = slot_ok[e] && (!mask_valid_i || mask_i[rel]);
		end
	end

	////////////////////
	// lane data
	////////////////////

	always_comb begin
		lane_data_o.d = '0;
		case (sew_i)
			2'd0: begin
				for (int e = 0; e < 8; e++) begin
					if (slot_ok[e]) lane_data_o.b[e] = line_i[slot_src[e] * 8 +: 8];
				end
			end
			2'd1: begin
				for (int e = 0; e < 4; e++) begin
					if (slot_ok[e]) lane_data_o.h[e] = line_i[slot_src[e] * 16 +: 16];
				end
			end
			2'd2: begin
				for (int e = 0; e < 2; e++) begin
					if (slot_ok[e]) lane_data_o.w[e] = line_i[slot_src[e] * 32 +: 32];
				end
			end
			default: begin
				if (slot_ok[0]) lane_data_o.d = line_i[slot_src[0] * 64 +: 64];
			end
		endcase
	end

	// every byte of a slot takes the slot's enable
	always_comb begin
		for (int b = 0; b < LANE_BYTES; b++) begin
			lane_be_o[b] = slot_be[b >> sew_i];
		end
	end

	// stride range set up by the tracker at grant
	always_comb begin
		if (el_count_i > 7'd1) begin
			a_elem_stride: assert final (elem_stride_i != '0 && elem_stride_i <= 3'd4)
				else $error("element stride out of range for a multi-element beat");
		end
	end

endmodule

`default_nettype wire

// File: hw/lmu_output_stage.sv
`default_nettype none

module lmu_output_stage #(
	parameter int NUM_LANES = 8
) (
	input  logic                                                clk_i,
	input  logic                                                rst_n_i,
	input  logic                                                kill_i,
	input  logic                                                beat_valid_i,
	input  lmu_data_pkg::lane_word_u [NUM_LANES-1:0]            lane_data_i,
	input  logic [NUM_LANES-1:0][lmu_data_pkg::LANE_BYTES-1:0]  lane_be_i,
	input  logic [lmu_seq_pkg::SB_WIDTH-1:0]                    sb_id_i,
	input  logic [lmu_seq_pkg::VSTART_WIDTH-1:0]                vstart_self_i,
	input  logic [lmu_seq_pkg::VSTART_WIDTH-1:0]                vstart_next_i,
	output logic                                                load_dvalid_o,
	output logic [NUM_LANES*lmu_data_pkg::LANE_BITS-1:0]        load_data_o,
	output logic [NUM_LANES*lmu_data_pkg::LANE_BYTES-1:0]       mask_o,
	output logic [lmu_seq_pkg::SB_WIDTH-1:0]                    sb_id_o,
	output logic [lmu_seq_pkg::VSTART_WIDTH-1:0]                vstart_self_o,
	output logic [lmu_seq_pkg::VSTART_WIDTH-1:0]                vstart_next_o
);
	import lmu_seq_pkg::*;
	import lmu_data_pkg::*;

	localparam int LINE_BITS = NUM_LANES * LANE_BITS;
	localparam int LINE_BYTES = NUM_LANES * LANE_BYTES;

	// a beat in a kill cycle is dropped
	logic capture;
	logic dvalid_q;
	logic [LINE_BYTES-1:0] mask_q;
	logic [LINE_BITS-1:0] data_q;
	logic [SB_WIDTH-1:0] sb_q;
	logic [VSTART_WIDTH-1:0] vs_self_q;
	logic [VSTART_WIDTH-1:0] vs_next_q;

	assign capture = beat_valid_i && !kill_i;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dvalid_q <= 1'b0;
			mask_q <= '0;
		end else begin
			dvalid_q <= capture;
			mask_q <= capture ? lane_be_i : '0;
		end
	end

	// lanes are read through the flat view
	always_ff @(posedge clk_i) begin
		if (capture) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				data_q[l * LANE_BITS +: LANE_BITS] <= lane_data_i[l].d;
			end
			sb_q <= sb_id_i;
			vs_self_q <= vstart_self_i;
			vs_next_q <= vstart_next_i;
		end
	end

	assign load_dvalid_o = dvalid_q;
	assign load_data_o = data_q;
	assign mask_o = mask_q;
	assign sb_id_o = sb_q;
	assign vstart_self_o = vs_self_q;
	assign vstart_next_o = vs_next_q;

endmodule

`default_nettype wire

// File: hw/lmu_top.sv
`default_nettype none

module lmu_top #(
	parameter int NUM_LANES = 8
) (
	input  logic                                          clk_i,
	input  logic                                          rst_n_i,
	input  logic                                          kill_i,
	input  logic                                          load_granted_i,
	input  logic [lmu_seq_pkg::SB_WIDTH-1:0]              granted_sb_id_i,
	input  logic                                          indexed_i,
	input  logic [lmu_seq_pkg::SEW_CODE_WIDTH-1:0]        sew_i,
	input  logic signed [lmu_seq_pkg::STRIDE_WIDTH-1:0]   stride_i,
	input  logic                                          sync_end_i,
	input  logic [lmu_seq_pkg::SB_WIDTH-1:0]              sync_end_sb_id_i,
	input  logic                                          data_valid_i,
	input  logic [NUM_LANES*lmu_data_pkg::LANE_BITS-1:0]  load_data_i,
	input  logic [lmu_seq_pkg::SEQ_ID_WIDTH-1:0]          seq_id_i,
	input  logic                                          mask_valid_i,
	input  logic [NUM_LANES*lmu_data_pkg::LANE_BYTES-1:0] mask_i,
	output logic                                          load_dvalid_o,
	output logic [NUM_LANES*lmu_data_pkg::LANE_BITS-1:0]  load_data_o,
	output logic [NUM_LANES*lmu_data_pkg::LANE_BYTES-1:0] mask_o,
	output logic [lmu_seq_pkg::SB_WIDTH-1:0]              sb_id_o,
	output logic [lmu_seq_pkg::VSTART_WIDTH-1:0]          vstart_self_o,
	output logic [lmu_seq_pkg::VSTART_WIDTH-1:0]          vstart_next_o
);
	import lmu_seq_pkg::*;
	import lmu_data_pkg::*;

	// beat fields from the tracker
	logic beat_valid;
	logic [SEW_CODE_WIDTH-1:0] beat_sew;
	logic beat_reverse;
	logic [ELEM_STRIDE_WIDTH-1:0] beat_elem_stride;
	logic [OFFSET_WIDTH-1:0] beat_offset;
	logic [EL_ID_WIDTH-1:0] beat_el_id;
	logic [EL_COUNT_WIDTH-1:0] beat_el_count;
	logic [SB_WIDTH-1:0] beat_sb_id;
	logic [VSTART_WIDTH-1:0] beat_vstart_self;
	logic [VSTART_WIDTH-1:0] beat_vstart_next;

	// per-lane results
	lane_word_u [NUM_LANES-1:0] lane_data;
	logic [NUM_LANES-1:0][LANE_BYTES-1:0] lane_be;

	lmu_load_tracker #(
		.NUM_LANES(NUM_LANES)
	) u_tracker (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.kill_i(kill_i),
		.load_granted_i(load_granted_i),
		.granted_sb_id_i(granted_sb_id_i),
		.indexed_i(indexed_i),
		.sew_i(sew_i),
		.stride_i(stride_i),
		.sync_end_i(sync_end_i),
		.sync_end_sb_id_i(sync_end_sb_id_i),
		.data_valid_i(data_valid_i),
		.seq_id_i(seq_id_i),
		.beat_valid_o(beat_valid),
		.sew_o(beat_sew),
		.reverse_o(beat_reverse),
		.elem_stride_o(beat_elem_stride),
		.offset_o(beat_offset),
		.el_id_o(beat_el_id),
		.el_count_o(beat_el_count),
		.sb_id_o(beat_sb_id),
		.vstart_self_o(beat_vstart_self),
		.vstart_next_o(beat_vstart_next)
	);

	for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lane
		lmu_lane_gather #(
			.NUM_LANES(NUM_LANES),
			.LANE_INDEX(g)
		) u_lane (
			.line_i(load_data_i),
			.sew_i(beat_sew),
			.reverse_i(beat_reverse),
			.elem_stride_i(beat_elem_stride),
			.offset_i(beat_offset),
			.el_id_i(beat_el_id),
			.el_count_i(beat_el_count),
			.mask_valid_i(mask_valid_i),
			.mask_i(mask_i),
			.lane_data_o(lane_data[g]),
			.lane_be_o(lane_be[g])
		);
	end

	lmu_output_stage #(
		.NUM_LANES(NUM_LANES)
	) u_output (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.kill_i(kill_i),
		.beat_valid_i(beat_valid),
		.lane_data_i(lane_data),
		.lane_be_i(lane_be),
		.sb_id_i(beat_sb_id),
		.vstart_self_i(beat_vstart_self),
		.vstart_next_i(beat_vstart_next),
		.load_dvalid_o(load_dvalid_o),
		.load_data_o(load_data_o),
		.mask_o(mask_o),
		.sb_id_o(sb_id_o),
		.vstart_self_o(vstart_self_o),
		.vstart_next_o(vstart_next_o)
	);

endmodule

`default_nettype wire

// File: tb/lmu_ref_model.svh
`ifndef LMU_REF_MODEL_SVH
`define LMU_REF_MODEL_SVH

// live loads, indexed by scoreboard id
logic [15:0] m_live;
logic [1:0] m_sew [0:15];
logic m_idx [0:15];
logic m_rev [0:15];
int m_estride [0:15];

function automatic int live_count();
	int n;
	n = 0;
	for (int i = 0; i < 16; i++) begin
		if (m_live[i]) n++;
	end
	return n;
endfunction

// one clock edge of table updates, kill wins
task automatic model_update(
	input logic kill,
	input logic grant,
	input logic [3:0] gid,
	input logic idx,
	input logic [1:0] sew,
	input logic signed [63:0] stride,
	input logic send,
	input logic [3:0] eid
);
	logic signed [63:0] mag;
	if (send) m_live[eid] = 1'b0;
	if (grant) begin
		mag = (stride < 0) ? -stride : stride;
		m_live[gid] = 1'b1;
		m_sew[gid] = sew;
		m_idx[gid] = idx;
		m_rev[gid] = (stride < 0) && !idx;
		m_estride[gid] = idx ? 1 : int'(mag) / (1 << sew);
	end
	if (kill) m_live = '0;
endtask

// element j goes from source (off + j*str) mod n to (el_id + j) mod n
function automatic logic [LINE_BITS-1:0] model_line(
	input logic [LINE_BITS-1:0] line,
	input logic [1:0] sew,
	input logic rev,
	input int str,
	input int off,
	input int el_id,
	input int cnt
);
	logic [LINE_BITS-1:0] res;
	int n;
	int w;
	int s;
	int d;
	n = LINE_BYTES >> sew;
	w = 8 << sew;
	res = '0;
	for (int j = 0; j < cnt; j++) begin
		s = (off + j * str) % n;
		// mirrored input for a reversed load
		if (rev) s = n - 1 - s;
		d = (el_id + j) % n;
		for (int b = 0; b < w; b++) begin
			res[d * w + b] = line[s * w + b];
		end
	end
	return res;
endfunction

function automatic logic [LINE_BYTES-1:0] model_mask(
	input logic [1:0] sew,
	input int el_id,
	input int cnt,
	input logic mv,
	input logic [LINE_BYTES-1:0] msk
);
	logic [LINE_BYTES-1:0] res;
	int n;
	int eb;
	int d;
	n = LINE_BYTES >> sew;
	eb = 1 << sew;
	res = '0;
	for (int j = 0; j < cnt; j++) begin
		d = (el_id + j) % n;
		for (int b = 0; b < eb; b++) begin
			res[d * eb + b] = !mv || msk[j];
		end
	end
	return res;
endfunction

`endif

// File: tb/lmu_tb.sv
`default_nettype none

module lmu_tb;
	import lmu_seq_pkg::*;
	import lmu_data_pkg::*;

	localparam int NUM_LANES = 8;
	localparam int LINE_BITS = NUM_LANES * LANE_BITS;
	localparam int LINE_BYTES = NUM_LANES * LANE_BYTES;
	localparam int NUM_CYCLES = 3000;

	logic clk_i;
	logic rst_n_i;
	logic kill_i;
	logic load_granted_i;
	logic [SB_WIDTH-1:0] granted_sb_id_i;
	logic indexed_i;
	logic [SEW_CODE_WIDTH-1:0] sew_i;
	logic signed [STRIDE_WIDTH-1:0] stride_i;
	logic sync_end_i;
	logic [SB_WIDTH-1:0] sync_end_sb_id_i;
	logic data_valid_i;
	logic [LINE_BITS-1:0] load_data_i;
	logic [SEQ_ID_WIDTH-1:0] seq_id_i;
	logic mask_valid_i;
	logic [LINE_BYTES-1:0] mask_i;
	logic load_dvalid_o;
	logic [LINE_BITS-1:0] load_data_o;
	logic [LINE_BYTES-1:0] mask_o;
	logic [SB_WIDTH-1:0] sb_id_o;
	logic [VSTART_WIDTH-1:0] vstart_self_o;
	logic [VSTART_WIDTH-1:0] vstart_next_o;

	// one entry per driven cycle
	typedef struct packed {
		logic vld;
		logic [LINE_BITS-1:0] line;
		logic [LINE_BYTES-1:0] mask;
		logic [SB_WIDTH-1:0] sb;
		logic [VSTART_WIDTH-1:0] vs_self;
		logic [VSTART_WIDTH-1:0] vs_next;
	} expect_t;

	expect_t exp_q[$];
	integer seed;
	int errors;
	int timeouts;
	int checks;
	int hits;
	int wait_cnt;

	`include "lmu_ref_model.svh"

	lmu_top #(
		.NUM_LANES(NUM_LANES)
	) dut (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.kill_i(kill_i),
		.load_granted_i(load_granted_i),
		.granted_sb_id_i(granted_sb_id_i),
		.indexed_i(indexed_i),
		.sew_i(sew_i),
		.stride_i(stride_i),
		.sync_end_i(sync_end_i),
		.sync_end_sb_id_i(sync_end_sb_id_i),
		.data_valid_i(data_valid_i),
		.load_data_i(load_data_i),
		.seq_id_i(seq_id_i),
		.mask_valid_i(mask_valid_i),
		.mask_i(mask_i),
		.load_dvalid_o(load_dvalid_o),
		.load_data_o(load_data_o),
		.mask_o(mask_o),
		.sb_id_o(sb_id_o),
		.vstart_self_o(vstart_self_o),
		.vstart_next_o(vstart_next_o)
	);

	always #4 clk_i = ~clk_i;

	function automatic int rnd(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// first id from a random start that is live, or free
	function automatic logic [3:0] pick_id(input logic want_live);
		int start;
		logic [3:0] id;
		logic found;
		start = rnd(16);
		id = 4'(start);
		found = 1'b0;
		for (int i = 0; i < 16; i++) begin
			if (!found && m_live[4'(start + i)] == want_live) begin
				id = 4'(start + i);
				found = 1'b1;
			end
		end
		return id;
	endfunction

	function automatic logic pending_beats();
		foreach (exp_q[i]) begin
			if (exp_q[i].vld) return 1'b1;
		end
		return 1'b0;
	endfunction

	////////////////////
	// output checks
	////////////////////

	task automatic check_outputs();
		expect_t e;
		e = exp_q.pop_front();
		checks++;
		if (load_dvalid_o !== e.vld) begin
			$display("Error at %0t: load_dvalid_o %b, expected %b", $time, load_dvalid_o, e.vld);
			errors++;
		end else if (e.vld) begin
			if (load_data_o !== e.line) begin
				$display("Error at %0t: load_data_o wrong for sb %0d", $time, e.sb);
				errors++;
			end
			if (mask_o !== e.mask) begin
				$display("Error at %0t: mask_o %h, expected %h", $time, mask_o, e.mask);
				errors++;
			end
			if (sb_id_o !== e.sb) begin
				$display("Error at %0t: sb_id_o %0d, expected %0d", $time, sb_id_o, e.sb);
				errors++;
			end
			if (vstart_self_o !== e.vs_self || vstart_next_o !== e.vs_next) begin
				$display("Error at %0t: vstart %0d/%0d, expected %0d/%0d", $time,
					vstart_self_o, vstart_next_o, e.vs_self, e.vs_next);
				errors++;
			end
		end else if (mask_o !== '0) begin
			$display("Error at %0t: mask_o %h without a valid beat", $time, mask_o);
			errors++;
		end
	endtask

	////////////////////
	// stimulus
	////////////////////

	// drive one cycle on the rising edge, check the previous one at the falling edge
	task automatic run_cycle(input logic traffic);
		logic kill;
		logic grant;
		logic [3:0] gid;
		logic idx;
		logic [1:0] sew;
		logic signed [63:0] stride;
		logic send;
		logic [3:0] eid;
		logic beat;
		logic [3:0] bid;
		logic mv;
		logic [LINE_BYTES-1:0] msk;
		logic [LINE_BITS-1:0] line;
		int cnt;
		int off;
		int el_id;
		expect_t e;
		@(posedge clk_i);
		kill = traffic && rnd(64) == 0;
		grant = traffic && !kill && live_count() < 2 && rnd(4) == 0;
		gid = pick_id(1'b0);
		idx = rnd(4) == 0;
		sew = 2'(rnd(4));
		stride = 64'((1 + rnd(4)) << sew);
		if (rnd(2) == 1) stride = -stride;
		send = traffic && !kill && live_count() > 0 && rnd(8) == 0;
		eid = pick_id(1'b1);
		beat = traffic && rnd(2) == 0;
		// mostly live ids, some dead ones
		bid = (live_count() > 0 && rnd(8) != 0) ? pick_id(1'b1) : 4'(rnd(16));
		if (m_live[bid]) cnt = m_idx[bid] ? 1 : 1 + rnd(LINE_BYTES >> m_sew[bid]);
		else cnt = 1 + rnd(8);
		off = rnd(64);
		el_id = rnd(2048);
		mv = rnd(2) == 1;
		msk = {$random(seed), $random(seed)};
		for (int w = 0; w < LINE_BITS / 32; w++) begin
			line[w * 32 +: 32] = $random(seed);
		end
		kill_i <= kill;
		load_granted_i <= grant;
		granted_sb_id_i <= gid;
		indexed_i <= idx;
		sew_i <= sew;
		stride_i <= stride;
		sync_end_i <= send;
		sync_end_sb_id_i <= eid;
		data_valid_i <= beat;
		load_data_i <= line;
		seq_id_i <= {bid, EL_COUNT_WIDTH'(cnt), OFFSET_WIDTH'(off), EL_ID_WIDTH'(el_id),
			5'(rnd(32))};
		mask_valid_i <= mv;
		mask_i <= msk;
		// lookup sees the table before this edge's updates
		e = '0;
		e.vld = beat && m_live[bid] && !kill;
		if (e.vld) begin
			hits++;
			e.line = model_line(line, m_sew[bid], m_rev[bid], m_estride[bid], off, el_id, cnt);
			e.mask = model_mask(m_sew[bid], el_id, cnt, mv, msk);
			e.sb = bid;
			e.vs_self = VSTART_WIDTH'(el_id);
			e.vs_next = VSTART_WIDTH'(el_id + cnt);
		end
		exp_q.push_back(e);
		model_update(kill, grant, gid, idx, sew, stride, send, eid);
		@(negedge clk_i);
		check_outputs();
	endtask

	initial begin
		seed = 32'h8ffa;
		errors = 0;
		timeouts = 0;
		checks = 0;
		hits = 0;
		m_live = '0;
		clk_i = 1'b0;
		rst_n_i = 1'b0;
		kill_i = 1'b0;
		load_granted_i = 1'b0;
		granted_sb_id_i = '0;
		indexed_i = 1'b0;
		sew_i = '0;
		stride_i = '0;
		sync_end_i = 1'b0;
		sync_end_sb_id_i = '0;
		data_valid_i = 1'b0;
		load_data_i = '0;
		seq_id_i = '0;
		mask_valid_i = 1'b0;
		mask_i = '0;

		// outputs stay quiet through reset
		for (int c = 0; c < 10; c++) begin
			@(negedge clk_i);
			if (load_dvalid_o !== 1'b0 || mask_o !== '0) begin
				$display("Error at %0t: outputs not cleared in reset", $time);
				errors++;
			end
		end
		@(posedge clk_i);
		rst_n_i <= 1'b1;
		// idle cycle before traffic
		exp_q.push_back('0);

		for (int c = 0; c < NUM_CYCLES; c++) begin
			run_cycle(1'b1);
		end

		wait_cnt = 0;
		while (pending_beats() && wait_cnt < 16) begin
			run_cycle(1'b0);
			wait_cnt++;
		end
		if (pending_beats()) begin
			$display("timeout waiting for the last beats to leave the output stage");
			timeouts++;
		end
		if (hits == 0) begin
			$display("no beat hit a live load during the run");
			errors++;
		end

		$display("errors %0d, timeouts %0d, checks %0d, hits %0d", errors, timeouts, checks, hits);
		if (errors == 0 && timeouts == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+tb
hw/lmu_seq_pkg.sv
hw/lmu_data_pkg.sv
hw/lmu_load_tracker.sv
hw/lmu_lane_gather.sv
hw/lmu_output_stage.sv
hw/lmu_top.sv
tb/lmu_tb.sv

// File: Bender.yml
package:
  name: lmu

sources:
  - hw/lmu_seq_pkg.sv
  - hw/lmu_data_pkg.sv
  - hw/lmu_load_tracker.sv
  - hw/lmu_lane_gather.sv
  - hw/lmu_output_stage.sv
  - hw/lmu_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/lmu_tb.sv
